// File: files.f
src/dma_pkg.sv
src/dma_block_buffer.sv
src/dma_bus_engine.sv
src/dma_ctrl_regs.sv
src/wb_dma.sv
bench/wb_mem_model.sv
bench/wb_dma_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= wb_dma_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
PASS_TEXT ?= Everything OK
VFLAGS ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

# the run passes only if the pass line shows up in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/wb_dma_tb.sv
`timescale 1ns/1ps

module wb_dma_tb;

	localparam int MEM_WORDS = 4096;
	// cycles any single wait may take before it is reported
	localparam int WAIT_LIMIT = 50000;

	logic clk = 1'b0;
	logic reset;
	logic swb_cyc;
	logic swb_stb;
	logic swb_we;
	dma_pkg::reg_sel_t swb_addr;
	dma_pkg::word_t swb_wdata;
	logic swb_ack;
	dma_pkg::word_t swb_rdata;
	dma_pkg::wb_req_t mwb_req;
	dma_pkg::wb_rsp_t mwb_rsp;
	logic [dma_pkg::DEV_INTS_W-1:0] dev_ints;
	logic interrupt;
	logic err_en;
	dma_pkg::addr_t err_addr;

	// expected memory contents that are kept in step with every copy started
	dma_pkg::word_t shadow [0:MEM_WORDS-1];
	int unsigned mismatches = 0;
	int unsigned failures = 0;
	int unsigned irq_count = 0;
	bit cmp_req = 1'b0;

	wb_dma wb_dma_i (
		.i_clk       (clk),
		.i_reset     (reset),
		.i_swb_cyc   (swb_cyc),
		.i_swb_stb   (swb_stb),
		.i_swb_we    (swb_we),
		.i_swb_addr  (swb_addr),
		.i_swb_data  (swb_wdata),
		.o_swb_ack   (swb_ack),
		.o_swb_data  (swb_rdata),
		.o_mwb       (mwb_req),
		.i_mwb       (mwb_rsp),
		.i_dev_ints  (dev_ints),
		.o_interrupt (interrupt)
	);

	wb_mem_model mem_model_i (
		.i_clk      (clk),
		.i_reset    (reset),
		.i_req      (mwb_req),
		.o_rsp      (mwb_rsp),
		.i_err_en   (err_en),
		.i_err_addr (err_addr)
	);

	always #10 clk = ~clk;

	// the interrupt is a single cycle pulse and each one is seen on exactly one falling edge
	always @(negedge clk)
	begin
		if (!reset && interrupt)
			irq_count++;
	end

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input dma_pkg::word_t got,
			input dma_pkg::word_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input dma_pkg::addr_t got,
			input dma_pkg::addr_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input bit got, input bit exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// the memory checker runs once per request and then clears it
	always @(negedge clk)
	begin
		if (cmp_req)
		begin
			for (int i = 0; i < MEM_WORDS; i++)
				check_word($sformatf("mem[0x%03h]", i), mem_model_i.mem[i], shadow[i]);
			cmp_req = 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// copies word by word so a fixed source rereads one word
	// and a fixed destination keeps only the last one
	function automatic void ref_copy(input dma_pkg::addr_t src, input dma_pkg::addr_t dst,
			input int unsigned len, input bit incs, input bit incd);
		dma_pkg::addr_t s;
		dma_pkg::addr_t d;
		s = src;
		d = dst;
		for (int unsigned i = 0; i < len; i++)
		begin
			shadow[d[11:0]] = shadow[s[11:0]];
			if (incs)
				s = s + 1'b1;
			if (incd)
				d = d + 1'b1;
		end
	endfunction

	// builds word 0 with the increments active low in bits 29 and 28
	function automatic dma_pkg::word_t ctrl_word(input bit start, input bit incs, input bit incd,
			input bit trig, input dma_pkg::dev_id_t dev, input dma_pkg::blk_len_t blk);
		dma_pkg::word_t w;
		w = '0;
		w[29] = !incs;
		w[28] = !incd;
		if (start)
			w[27:16] = dma_pkg::START_KEY;
		w[15] = trig;
		w[14:10] = dev;
		w[9:0] = blk;
		return w;
	endfunction

	//////////////////////////////////////////////////
	// slave port and wait tasks
	//////////////////////////////////////////////////

	task automatic bus_write(input dma_pkg::reg_sel_t a, input dma_pkg::word_t d);
		int n;
		@(negedge clk);
		swb_cyc = 1'b1;
		swb_stb = 1'b1;
		swb_we = 1'b1;
		swb_addr = a;
		swb_wdata = d;
		@(negedge clk);
		swb_stb = 1'b0;
		n = 0;
		while (!swb_ack && n < 8)
		begin
			@(negedge clk);
			n++;
		end
		if (!swb_ack)
		begin
			failures++;
			$display("write to register %0d was never acknowledged", a);
		end
		swb_cyc = 1'b0;
		swb_we = 1'b0;
	endtask

	task automatic bus_read(input dma_pkg::reg_sel_t a, output dma_pkg::word_t d);
		int n;
		@(negedge clk);
		swb_cyc = 1'b1;
		swb_stb = 1'b1;
		swb_we = 1'b0;
		swb_addr = a;
		@(negedge clk);
		swb_stb = 1'b0;
		n = 0;
		while (!swb_ack && n < 8)
		begin
			@(negedge clk);
			n++;
		end
		if (!swb_ack)
		begin
			failures++;
			$display("read of register %0d was never acknowledged", a);
		end
		d = swb_rdata;
		swb_cyc = 1'b0;
	endtask

	task automatic wait_irq(input int unsigned target);
		int n;
		n = 0;
		while (irq_count < target && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (irq_count < target)
		begin
			failures++;
			$display("no interrupt arrived within %0d cycles", n);
		end
	endtask

	task automatic wait_writes(input int unsigned target);
		int n;
		n = 0;
		while (mem_model_i.wr_count < target && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (mem_model_i.wr_count < target)
		begin
			failures++;
			$display("destination writes did not reach %0d within %0d cycles", target, n);
		end
	endtask

	task automatic wait_idle();
		dma_pkg::word_t rd;
		int n;
		rd = '1;
		n = 0;
		while (rd[31] && n < 200)
		begin
			bus_read(dma_pkg::REG_CTRL, rd);
			n++;
		end
		if (rd[31])
		begin
			failures++;
			$display("controller never returned to idle");
		end
	endtask

	// hand the comparison to the checker process and wait until it has run
	task automatic compare_mem();
		int n;
		cmp_req = 1'b1;
		n = 0;
		while (cmp_req && n < 4)
		begin
			@(negedge clk);
			n++;
		end
		if (cmp_req)
		begin
			failures++;
			$display("memory comparison never ran");
		end
	endtask

	task automatic start_copy(input dma_pkg::addr_t src, input dma_pkg::addr_t dst,
			input int unsigned len, input bit incs, input bit incd,
			input dma_pkg::blk_len_t blk, input bit trig, input dma_pkg::dev_id_t dev);
		bus_write(dma_pkg::REG_LEN, dma_pkg::word_t'(len));
		bus_write(dma_pkg::REG_SRC, {src, 2'b00});
		bus_write(dma_pkg::REG_DST, {dst, 2'b00});
		bus_write(dma_pkg::REG_CTRL, ctrl_word(1'b1, incs, incd, trig, dev, blk));
	endtask

	// a plain copy must end in one interrupt, an idle controller and matching memory
	task automatic run_copy(input dma_pkg::addr_t src, input dma_pkg::addr_t dst,
			input int unsigned len, input bit incs, input bit incd,
			input dma_pkg::blk_len_t blk);
		dma_pkg::word_t rd;
		int unsigned base;
		base = irq_count;
		start_copy(src, dst, len, incs, incd, blk, 1'b0, '0);
		ref_copy(src, dst, len, incs, incd);
		wait_irq(base + 1);
		repeat (20) @(negedge clk);
		check_word("interrupt pulses", dma_pkg::word_t'(irq_count - base), 32'd1);
		bus_read(dma_pkg::REG_CTRL, rd);
		check_flag("busy", rd[31], 1'b0);
		check_flag("error", rd[30], 1'b0);
		compare_mem();
	endtask

	//////////////////////////////////////////////////
	// scenarios
	//////////////////////////////////////////////////

	initial
	begin
		dma_pkg::word_t rd;
		int unsigned base;
		int unsigned wbase;
		int unsigned expect_wr;
		void'($urandom(85));
		reset = 1'b1;
		swb_cyc = 1'b0;
		swb_stb = 1'b0;
		swb_we = 1'b0;
		swb_addr = '0;
		swb_wdata = '0;
		dev_ints = '0;
		err_en = 1'b0;
		err_addr = '0;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			mem_model_i.mem[i] = $urandom;
			shadow[i] = mem_model_i.mem[i];
		end
		repeat (10) @(negedge clk);
		reset = 1'b0;

		// register read-back while idle
		bus_write(dma_pkg::REG_LEN, 32'h0000_0123);
		bus_write(dma_pkg::REG_SRC, {30'h48c, 2'b00});
		bus_write(dma_pkg::REG_DST, {30'h2af0, 2'b00});
		bus_write(dma_pkg::REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b1, 1'b1, 5'd7, 10'd5));
		bus_read(dma_pkg::REG_LEN, rd);
		check_addr("len", rd[29:0], 30'h123);
		bus_read(dma_pkg::REG_SRC, rd);
		check_addr("src", rd[31:2], 30'h48c);
		bus_read(dma_pkg::REG_DST, rd);
		check_addr("dst", rd[31:2], 30'h2af0);
		bus_read(dma_pkg::REG_CTRL, rd);
		check_flag("incs", !rd[29], 1'b0);
		check_flag("incd", !rd[28], 1'b1);
		check_flag("trigger", rd[15], 1'b1);
		check_word("dev id", dma_pkg::word_t'(rd[14:10]), 32'd7);
		check_word("block length", dma_pkg::word_t'(rd[9:0]), 32'd5);
		check_flag("busy", rd[31], 1'b0);

		// an incrementing copy in one full size block leaves the length at zero
		run_copy(30'h100, 30'h800, 37, 1'b1, 1'b1, 10'd0);
		bus_read(dma_pkg::REG_LEN, rd);
		check_addr("len", rd[29:0], '0);

		run_copy(30'h200, 30'h900, 10, 1'b0, 1'b1, 10'd4);
		run_copy(30'h300, 30'ha00, 12, 1'b1, 1'b0, 10'd5);

		// device triggered blocks of 8, 8 and 4 words on line 3
		base = irq_count;
		wbase = mem_model_i.wr_count;
		start_copy(30'h400, 30'hb00, 20, 1'b1, 1'b1, 10'd8, 1'b1, 5'd3);
		ref_copy(30'h400, 30'hb00, 20, 1'b1, 1'b1);
		repeat (100) @(negedge clk);
		check_word("writes before trigger", dma_pkg::word_t'(mem_model_i.wr_count - wbase), 0);
		for (int b = 1; b <= 3; b++)
		begin
			expect_wr = (b * 8 < 20) ? b * 8 : 20;
			dev_ints[3] = 1'b1;
			@(negedge clk);
			dev_ints[3] = 1'b0;
			wait_writes(wbase + expect_wr);
			repeat (100) @(negedge clk);
			check_word("writes after trigger",
					dma_pkg::word_t'(mem_model_i.wr_count - wbase), expect_wr);
		end
		wait_irq(base + 1);
		check_word("interrupt pulses", dma_pkg::word_t'(irq_count - base), 32'd1);
		compare_mem();

		// a bus error on one source word stops before anything is written
		base = irq_count;
		err_addr = 30'h505;
		err_en = 1'b1;
		start_copy(30'h500, 30'hc00, 16, 1'b1, 1'b1, 10'd16, 1'b0, '0);
		wait_irq(base + 1);
		repeat (20) @(negedge clk);
		err_en = 1'b0;
		check_word("interrupt pulses", dma_pkg::word_t'(irq_count - base), 32'd1);
		bus_read(dma_pkg::REG_CTRL, rd);
		check_flag("error", rd[30], 1'b1);
		check_flag("busy", rd[31], 1'b0);
		compare_mem();

		// a long copy is aborted part way and the memory it leaves is not defined
		base = irq_count;
		start_copy(30'h000, 30'h800, 1000, 1'b1, 1'b1, 10'd0, 1'b0, '0);
		repeat (50) @(negedge clk);
		bus_read(dma_pkg::REG_CTRL, rd);
		check_flag("busy", rd[31], 1'b1);
		bus_write(dma_pkg::REG_CTRL, dma_pkg::ABORT_WORD);
		wait_idle();
		repeat (20) @(negedge clk);
		bus_read(dma_pkg::REG_CTRL, rd);
		check_flag("error", rd[30], 1'b1);
		check_flag("busy", rd[31], 1'b0);
		check_word("interrupt pulses", dma_pkg::word_t'(irq_count - base), 32'd0);

		$display("%0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: bench/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
	input  logic             i_clk,
	input  logic             i_reset,
	input  dma_pkg::wb_req_t i_req,
	output dma_pkg::wb_rsp_t o_rsp,
	input  logic             i_err_en,
	input  dma_pkg::addr_t   i_err_addr
);

	localparam int MEM_WORDS = 4096;

	// one accepted request waiting for its ack, the read data is taken when it is accepted
	typedef struct packed {
		logic err;
		dma_pkg::word_t data;
		logic [31:0] due;
	} pend_t;

	dma_pkg::word_t mem [0:MEM_WORDS-1];
	pend_t pending [$];
	logic [31:0] cycle = '0;
	int unsigned wr_count = 0;

	initial o_rsp = '0;

	//////////////////////////////////////////////////
	// request side, sampled on the rising edge
	//////////////////////////////////////////////////

	always @(posedge i_clk)
	begin
		pend_t p;
		cycle = cycle + 1;
		if (i_reset || !i_req.cyc)
			pending.delete();
		else if (i_req.stb && !o_rsp.stall)
		begin
			// only reads of the selected address fail, writes always succeed
			p.err = i_err_en && !i_req.we && (i_req.addr == i_err_addr);
			p.data = mem[i_req.addr[11:0]];
			// ack comes back zero to two cycles later than the earliest point
			p.due = cycle + ($urandom % 3);
			if (i_req.we)
			begin
				mem[i_req.addr[11:0]] = i_req.data;
				wr_count++;
			end
			pending.push_back(p);
		end
	end

	//////////////////////////////////////////////////
	// response side, driven on the falling edge
	//////////////////////////////////////////////////

	always @(negedge i_clk)
	begin
		pend_t p;
		if (i_reset || !i_req.cyc)
		begin
			// a dropped cycle throws away anything still in flight
			pending.delete();
			o_rsp = '0;
		end
		else
		begin
			// roughly one cycle in four is stalled
			o_rsp.stall = (($urandom % 4) == 0);
			o_rsp.ack = 1'b0;
			o_rsp.err = 1'b0;
			if ((pending.size() != 0) && (pending[0].due <= cycle))
			begin
				p = pending.pop_front();
				o_rsp.ack = !p.err;
				o_rsp.err = p.err;
				o_rsp.data = p.data;
			end
		end
	end

endmodule

// File: src/wb_dma.sv
`timescale 1ns/1ps

module wb_dma (
	input  logic                           i_clk,
	input  logic                           i_reset,
	input  logic                           i_swb_cyc,
	input  logic                           i_swb_stb,
	input  logic                           i_swb_we,
	input  dma_pkg::reg_sel_t              i_swb_addr,
	input  dma_pkg::word_t                 i_swb_data,
	output logic                           o_swb_ack,
	output dma_pkg::word_t                 o_swb_data,
	output dma_pkg::wb_req_t               o_mwb,
	input  dma_pkg::wb_rsp_t               i_mwb,
	input  logic [dma_pkg::DEV_INTS_W-1:0] i_dev_ints,
	output logic                           o_interrupt
);

	//////////////////////////////////////////////////
	// control block to engine
	//////////////////////////////////////////////////

	dma_pkg::dma_cfg_t cfg;
	logic start;
	logic abort;
	logic trigger;

	// engine status and events back to the control block
	dma_pkg::dma_status_t status;
	logic blk_go_ack;
	logic done;
	logic bus_err;

	// engine to block buffer
	logic buf_we;
	dma_pkg::blk_cnt_t buf_waddr;
	logic buf_rd_rst;
	logic buf_rd_adv;
	dma_pkg::word_t buf_rdata;

	dma_ctrl_regs dma_ctrl_regs_i (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_swb_cyc    (i_swb_cyc),
		.i_swb_stb    (i_swb_stb),
		.i_swb_we     (i_swb_we),
		.i_swb_addr   (i_swb_addr),
		.i_swb_data   (i_swb_data),
		.o_swb_ack    (o_swb_ack),
		.o_swb_data   (o_swb_data),
		.i_dev_ints   (i_dev_ints),
		.i_status     (status),
		.i_blk_go_ack (blk_go_ack),
		.i_done       (done),
		.i_bus_err    (bus_err),
		.o_cfg        (cfg),
		.o_start      (start),
		.o_abort      (abort),
		.o_trigger    (trigger),
		.o_interrupt  (o_interrupt)
	);

	dma_bus_engine dma_bus_engine_i (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_cfg        (cfg),
		.i_start      (start),
		.i_abort      (abort),
		.i_trigger    (trigger),
		.o_mwb        (o_mwb),
		.i_mwb        (i_mwb),
		.o_status     (status),
		.o_blk_go_ack (blk_go_ack),
		.o_done       (done),
		.o_bus_err    (bus_err),
		.o_buf_we     (buf_we),
		.o_buf_waddr  (buf_waddr),
		.o_buf_rd_rst (buf_rd_rst),
		.o_buf_rd_adv (buf_rd_adv),
		.i_buf_rdata  (buf_rdata)
	);

	// read data from the bus lands in the buffer and leaves it as write data
	dma_block_buffer dma_block_buffer_i (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_we     (buf_we),
		.i_waddr  (buf_waddr),
		.i_wdata  (i_mwb.data),
		.i_rd_rst (buf_rd_rst),
		.i_rd_adv (buf_rd_adv),
		.o_rdata  (buf_rdata)
	);

endmodule

// File: src/dma_ctrl_regs.sv
`timescale 1ns/1ps

module dma_ctrl_regs (
	input  logic                              i_clk,
	input  logic                              i_reset,
	input  logic                              i_swb_cyc,
	input  logic                              i_swb_stb,
	input  logic                              i_swb_we,
	input  dma_pkg::reg_sel_t                 i_swb_addr,
	input  dma_pkg::word_t                    i_swb_data,
	output logic                              o_swb_ack,
	output dma_pkg::word_t                    o_swb_data,
	input  logic [dma_pkg::DEV_INTS_W-1:0]    i_dev_ints,
	input  dma_pkg::dma_status_t              i_status,
	input  logic                              i_blk_go_ack,
	input  logic                              i_done,
	input  logic                              i_bus_err,
	output dma_pkg::dma_cfg_t                 o_cfg,
	output logic                              o_start,
	output logic                              o_abort,
	output logic                              o_trigger,
	output logic                              o_interrupt
);

	logic s_wr;
	logic ctrl_wr;
	logic ctrl_wr_idle;
	logic start_cmd;
	logic abort_cmd;
	logic go_ok;
	logic armed;
	logic incs;
	logic incd;
	logic on_trig;
	logic err_flag;
	dma_pkg::dev_id_t dev_id;
	dma_pkg::blk_len_t blk_len_m1;

	//////////////////////////////////////////////////
	// slave write decode
	//////////////////////////////////////////////////

	assign s_wr = i_swb_cyc && i_swb_stb && i_swb_we;
	assign ctrl_wr = s_wr && (i_swb_addr == dma_pkg::REG_CTRL);

	// setup writes only land while the engine is idle and others are acked and dropped
	assign ctrl_wr_idle = ctrl_wr && !i_status.busy;

	// the start key needs bits 31..30 clear and something left to move
	assign start_cmd = ctrl_wr_idle
			&& (i_swb_data[27:16] == dma_pkg::START_KEY)
			&& (i_swb_data[31:30] == 2'b00)
			&& (i_status.len != '0);
	assign abort_cmd = ctrl_wr && i_status.busy && (i_swb_data == dma_pkg::ABORT_WORD);

	// every strobe gets exactly one ack on the next cycle whether it reads or writes
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_swb_ack <= 1'b0;
		else
			o_swb_ack <= i_swb_cyc && i_swb_stb;
	end

	// in the control word the bus bits 29 and 28 are the active low increment enables
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			incs <= 1'b0;
			incd <= 1'b0;
			on_trig <= 1'b0;
			dev_id <= '0;
			blk_len_m1 <= '1;
		end
		else if (ctrl_wr_idle)
		begin
			incs <= !i_swb_data[29];
			incd <= !i_swb_data[28];
			on_trig <= i_swb_data[15];
			dev_id <= i_swb_data[14:10];
			// a zero field wraps to all ones and so gives a full block
			blk_len_m1 <= i_swb_data[dma_pkg::BLK_W-1:0] - 1'b1;
		end
	end

	// the live length and addresses sit in the engine which takes the write itself
	always_comb
	begin
		o_cfg.incs = incs;
		o_cfg.incd = incd;
		o_cfg.blk_len_m1 = blk_len_m1;
		o_cfg.wdata = i_swb_data;
		o_cfg.wr_len = s_wr && !i_status.busy && (i_swb_addr == dma_pkg::REG_LEN);
		o_cfg.wr_src = s_wr && !i_status.busy && (i_swb_addr == dma_pkg::REG_SRC);
		o_cfg.wr_dst = s_wr && !i_status.busy && (i_swb_addr == dma_pkg::REG_DST);
	end

	//////////////////////////////////////////////////
	// commands and block trigger
	//////////////////////////////////////////////////

	// start and abort reach the engine one cycle after the strobe
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_start <= 1'b0;
			o_abort <= 1'b0;
		end
		else
		begin
			o_start <= start_cmd;
			o_abort <= abort_cmd;
		end
	end

	assign go_ok = !on_trig || i_dev_ints[dev_id];

	// the engine pulses blk_go_ack as it enters WAIT
	// without device triggering the block is released on the very next cycle
	// otherwise the request stays armed until the chosen line is seen high
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			armed <= 1'b0;
			o_trigger <= 1'b0;
		end
		else
		begin
			armed <= (armed || i_blk_go_ack) && !go_ok && !o_abort;
			o_trigger <= (armed || i_blk_go_ack) && go_ok;
		end
	end

	//////////////////////////////////////////////////
	// error flag, interrupt and read-back
	//////////////////////////////////////////////////

	// cleared by any control write while idle and set on a bus error or an abort
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			err_flag <= 1'b0;
		else if (ctrl_wr_idle)
			err_flag <= 1'b0;
		else if (i_bus_err || o_abort)
			err_flag <= 1'b1;
	end

	// an abort ends the transfer quietly and only done and bus errors interrupt
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_interrupt <= 1'b0;
		else
			o_interrupt <= i_done || i_bus_err;
	end

	// read data is registered so it is valid with the ack
	// the block field reads back the way it was written, zero for a full block
	always_ff @(posedge i_clk)
	begin
		case (i_swb_addr)
		dma_pkg::REG_CTRL:
			o_swb_data <= {i_status.busy, err_flag, !incs, !incd, 1'b0,
					i_status.nread, on_trig, dev_id,
					dma_pkg::blk_len_t'(blk_len_m1 + 1'b1)};
		dma_pkg::REG_LEN:
			o_swb_data <= {{(32 - dma_pkg::ADDR_W){1'b0}}, i_status.len};
		dma_pkg::REG_SRC:
			o_swb_data <= {i_status.raddr, 2'b00};
		default:
			o_swb_data <= {i_status.waddr, 2'b00};
		endcase
	end

endmodule

// File: src/dma_bus_engine.sv
`timescale 1ns/1ps

module dma_bus_engine (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  dma_pkg::dma_cfg_t    i_cfg,
	input  logic                 i_start,
	input  logic                 i_abort,
	input  logic                 i_trigger,
	output dma_pkg::wb_req_t     o_mwb,
	input  dma_pkg::wb_rsp_t     i_mwb,
	output dma_pkg::dma_status_t o_status,
	output logic                 o_blk_go_ack,
	output logic                 o_done,
	output logic                 o_bus_err,
	output logic                 o_buf_we,
	output dma_pkg::blk_cnt_t    o_buf_waddr,
	output logic                 o_buf_rd_rst,
	output logic                 o_buf_rd_adv,
	input  dma_pkg::word_t       i_buf_rdata
);

	dma_pkg::dma_state_e state;
	dma_pkg::addr_t raddr;
	dma_pkg::addr_t waddr;
	dma_pkg::addr_t len;
	dma_pkg::addr_t mwb_addr;
	dma_pkg::blk_cnt_t blk_words;
	dma_pkg::blk_cnt_t nrreq;
	dma_pkg::blk_cnt_t nrack;
	dma_pkg::blk_cnt_t nwreq;
	dma_pkg::blk_cnt_t nwack;
	dma_pkg::blk_cnt_t nrreq_n;
	dma_pkg::blk_cnt_t nrack_n;
	dma_pkg::blk_cnt_t nwreq_n;
	dma_pkg::blk_cnt_t nwack_n;
	logic rd_issue;
	logic rd_ack;
	logic wr_issue;
	logic wr_ack;
	logic rd_clr;
	logic wr_clr;
	logic last_rreq;
	logic last_rack;
	logic last_wreq;
	logic last_wack;
	logic final_ack;

	//////////////////////////////////////////////////
	// master bus outputs
	//////////////////////////////////////////////////

	// cyc covers both the request and the ack phase of each direction
	always_comb
	begin
		o_mwb.cyc = (state == dma_pkg::READ_REQ) || (state == dma_pkg::READ_ACK)
				|| (state == dma_pkg::WRITE_REQ) || (state == dma_pkg::WRITE_ACK);
		o_mwb.stb = (state == dma_pkg::READ_REQ) || (state == dma_pkg::WRITE_REQ);
		// we rises in PRE_WRITE already so the write counters leave reset early
		o_mwb.we = (state == dma_pkg::PRE_WRITE) || (state == dma_pkg::WRITE_REQ)
				|| (state == dma_pkg::WRITE_ACK);
		o_mwb.addr = mwb_addr;
		o_mwb.data = i_buf_rdata;
	end

	assign rd_issue = (state == dma_pkg::READ_REQ) && !i_mwb.stall;
	assign wr_issue = (state == dma_pkg::WRITE_REQ) && !i_mwb.stall;
	assign rd_ack = o_mwb.cyc && !o_mwb.we && i_mwb.ack;
	assign wr_ack = o_mwb.cyc && o_mwb.we && i_mwb.ack;
	assign rd_clr = (state == dma_pkg::IDLE) || (state == dma_pkg::WAIT);
	assign wr_clr = !o_mwb.we;

	// words in this block, the smaller of the block length and what is left
	assign blk_words = (len > dma_pkg::addr_t'(i_cfg.blk_len_m1))
			? {1'b0, i_cfg.blk_len_m1} + 1'b1
			: len[dma_pkg::BLK_W:0];

	assign final_ack = wr_ack && last_wack;
	// the length still holds the final word here since it drops on this ack
	assign o_done = final_ack && (len <= dma_pkg::addr_t'(1));
	assign o_bus_err = o_mwb.cyc && i_mwb.err;

	//////////////////////////////////////////////////
	// transfer state machine
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= dma_pkg::IDLE;
			o_blk_go_ack <= 1'b0;
		end
		else
		begin
			o_blk_go_ack <= 1'b0;
			// an abort or a bus error drops everything, in flight requests included
			if (i_abort || o_bus_err)
				state <= dma_pkg::IDLE;
			else
			begin
				case (state)
				dma_pkg::IDLE:
					if (i_start)
					begin
						state <= dma_pkg::WAIT;
						o_blk_go_ack <= 1'b1;
					end
				dma_pkg::WAIT:
					if (i_trigger)
						state <= dma_pkg::READ_REQ;
				dma_pkg::READ_REQ, dma_pkg::READ_ACK:
				begin
					if (rd_issue && last_rreq)
						state <= dma_pkg::READ_ACK;
					// the last ack wins even if it lands with the last request
					if (rd_ack && last_rack)
						state <= dma_pkg::PRE_WRITE;
				end
				dma_pkg::PRE_WRITE:
					state <= dma_pkg::WRITE_REQ;
				dma_pkg::WRITE_REQ, dma_pkg::WRITE_ACK:
				begin
					if (wr_issue && last_wreq)
						state <= dma_pkg::WRITE_ACK;
					if (final_ack)
					begin
						state <= o_done ? dma_pkg::IDLE : dma_pkg::WAIT;
						o_blk_go_ack <= !o_done;
					end
				end
				default:
					state <= dma_pkg::IDLE;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// request and ack counters
	//////////////////////////////////////////////////

	// read counters live through the write phase, the buffer is drained against nrack
	assign nrreq_n = rd_clr ? '0 : nrreq + dma_pkg::blk_cnt_t'(rd_issue);
	assign nrack_n = rd_clr ? '0 : nrack + dma_pkg::blk_cnt_t'(rd_ack);
	assign nwreq_n = wr_clr ? '0 : nwreq + dma_pkg::blk_cnt_t'(wr_issue);
	assign nwack_n = wr_clr ? '0 : nwack + dma_pkg::blk_cnt_t'(wr_ack);

	// the last flags look one step ahead, so a request can go out every cycle
	// while earlier ones are still waiting for their acks
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			nrreq <= '0;
			nrack <= '0;
			nwreq <= '0;
			nwack <= '0;
			last_rreq <= 1'b0;
			last_rack <= 1'b0;
			last_wreq <= 1'b0;
			last_wack <= 1'b0;
		end
		else
		begin
			nrreq <= nrreq_n;
			nrack <= nrack_n;
			nwreq <= nwreq_n;
			nwack <= nwack_n;
			last_rreq <= (nrreq_n + 1'b1 == blk_words);
			last_rack <= (nrack_n + 1'b1 == blk_words);
			last_wreq <= (nwreq_n + 1'b1 == nrack_n);
			last_wack <= (nwack_n + 1'b1 == nrack_n);
		end
	end

	//////////////////////////////////////////////////
	// length and addresses
	//////////////////////////////////////////////////

	// the length counts down on every write ack, so it reads as words still owed
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			len <= '0;
		else if (i_cfg.wr_len)
			len <= i_cfg.wdata[dma_pkg::ADDR_W-1:0];
		else if (wr_ack)
			len <= len - 1'b1;
	end

	// the source moves on read acks and the destination on accepted writes
	always_ff @(posedge i_clk)
	begin
		if (i_cfg.wr_src)
			raddr <= i_cfg.wdata[31:2];
		else if (rd_ack && i_cfg.incs)
			raddr <= raddr + 1'b1;

		if (i_cfg.wr_dst)
			waddr <= i_cfg.wdata[31:2];
		else if (wr_issue && i_cfg.incd)
			waddr <= waddr + 1'b1;

		// the bus address runs ahead of raddr while reads are outstanding
		if (rd_clr)
			mwb_addr <= raddr;
		else if (state == dma_pkg::PRE_WRITE)
			mwb_addr <= waddr;
		else if ((rd_issue && i_cfg.incs) || (wr_issue && i_cfg.incd))
			mwb_addr <= mwb_addr + 1'b1;
	end

	// read data goes straight into the buffer at the ack count
	assign o_buf_we = rd_ack;
	assign o_buf_waddr = nrack;
	assign o_buf_rd_rst = (state == dma_pkg::PRE_WRITE);
	assign o_buf_rd_adv = wr_issue;

	always_comb
	begin
		o_status.busy = (state != dma_pkg::IDLE);
		o_status.nread = nrack;
		o_status.len = len;
		o_status.raddr = raddr;
		o_status.waddr = waddr;
	end

endmodule

// File: src/dma_block_buffer.sv
`timescale 1ns/1ps

module dma_block_buffer (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_we,
	input  dma_pkg::blk_cnt_t i_waddr,
	input  dma_pkg::word_t    i_wdata,
	input  logic              i_rd_rst,
	input  logic              i_rd_adv,
	output dma_pkg::word_t    o_rdata
);

	dma_pkg::word_t mem [0:(1 << dma_pkg::BLK_W) - 1];
	dma_pkg::blk_len_t rd_ptr;
	dma_pkg::blk_len_t rd_addr;

	// a block never holds more than 1024 words, so the count's top bit is not needed
	always_ff @(posedge i_clk)
	begin
		if (i_we)
			mem[i_waddr[dma_pkg::BLK_W-1:0]] <= i_wdata;
	end

	// the pointer always sits one word past the one on o_rdata
	assign rd_addr = i_rd_rst ? '0 : rd_ptr;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			rd_ptr <= '0;
		else if (i_rd_rst || i_rd_adv)
			rd_ptr <= rd_addr + 1'b1;
	end

	// held under stall, so the bus sees the same word until it is accepted
	always_ff @(posedge i_clk)
	begin
		if (i_rd_rst || i_rd_adv)
			o_rdata <= mem[rd_addr];
	end

endmodule

// File: src/dma_pkg.sv
package dma_pkg;

	//////////////////////////////////////////////////
	// widths fixed by the register map
	//////////////////////////////////////////////////

	// word address width on the master bus, byte address bits 31..2
	localparam int ADDR_W = 30;
	// block length field in word 0, bits 9..0
	localparam int BLK_W = 10;
	// device id field in word 0, bits 14..10
	localparam int DEV_W = 5;
	// one line per possible device id
	localparam int DEV_INTS_W = 32;

	typedef logic [31:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	// block length minus one, so zero in the field gives a full 1024-word block
	typedef logic [BLK_W-1:0] blk_len_t;
	// one extra bit so a full block of 1024 words can be counted
	typedef logic [BLK_W:0] blk_cnt_t;
	typedef logic [DEV_W-1:0] dev_id_t;
	typedef logic [1:0] reg_sel_t;

	// engine states, a block is read fully before any of it is written
	typedef enum logic [2:0] {
		IDLE = 3'd0,
		WAIT,
		READ_REQ,
		READ_ACK,
		PRE_WRITE,
		WRITE_REQ,
		WRITE_ACK
	} dma_state_e;

	//////////////////////////////////////////////////
	// bundles
	//////////////////////////////////////////////////

	// master side request, driven by the engine
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		addr_t addr;
		word_t data;
	} wb_req_t;

	// master side response from the bus
	typedef struct packed {
		logic stall;
		logic ack;
		logic err;
		word_t data;
	} wb_rsp_t;

	// settings and pending register writes from the control block
	typedef struct packed {
		logic incs;
		logic incd;
		blk_len_t blk_len_m1;
		word_t wdata;
		logic wr_len;
		logic wr_src;
		logic wr_dst;
	} dma_cfg_t;

	// live engine state for read-back
	typedef struct packed {
		logic busy;
		blk_cnt_t nread;
		addr_t len;
		addr_t raddr;
		addr_t waddr;
	} dma_status_t;

	// register addresses on the slave port
	localparam reg_sel_t REG_CTRL = 2'd0;
	localparam reg_sel_t REG_LEN = 2'd1;
	localparam reg_sel_t REG_SRC = 2'd2;
	localparam reg_sel_t REG_DST = 2'd3;

	// key in bits 27..16 of a control write that starts a transfer
	localparam logic [11:0] START_KEY = 12'hfed;
	// a control write of exactly this word aborts a running transfer
	localparam word_t ABORT_WORD = 32'hffed0000;

endpackage
